// File: axi_pkg.sv
/*
  AXI3 general-purpose port definitions shared by the slave and the testbench.
  Widths match the PS GP0 master port; response and burst codes follow the spec.
*/

package axi_pkg;

  //////////////////////////////
  // Widths

  localparam int unsigned AXI_AW = 32;
  localparam int unsigned AXI_DW = 32;
  localparam int unsigned AXI_IW = 12;
  // AXI3 length field on the GP port
  localparam int unsigned AXI_LW = 4;
  localparam int unsigned AXI_SZW = 3;
  localparam int unsigned AXI_SW = AXI_DW / 8;

  //////////////////////////////
  // Encodings

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Only single beats are served, so the burst type has no effect
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

endpackage

// File: sys_pkg.sv
/*
  System bus and register map definitions.
  Used by the AXI slave, the register bank and the frame generator.
*/

package sys_pkg;

  //////////////////////////////
  // Bus widths

  localparam int unsigned SYS_AW = 32;
  localparam int unsigned SYS_DW = 32;
  // Low address bits decoded by the register bank
  localparam int unsigned REG_AW = 8;

  //////////////////////////////
  // Register map

  // Byte offsets of 32-bit registers
  typedef enum logic [REG_AW-1:0] {
    REG_ID          = 8'h00,
    REG_SCRATCH     = 8'h04,
    REG_FRAME_LEN   = 8'h08,
    REG_FRAME_SEED  = 8'h0C,
    REG_FRAME_START = 8'h10,
    REG_STATUS      = 8'h14
  } sys_reg_e;

  // Frame length and seed fields
  localparam int unsigned FRM_W = 16;

  //////////////////////////////
  // Status layout

  localparam int unsigned STS_BUSY_BIT = 0;
  // Completed frame counter
  localparam int unsigned STS_CNT_LSB = 16;
  localparam int unsigned STS_CNT_W = 16;

endpackage

// File: axi4_slave.sv
/*
  Single-beat AXI slave acting as master of the system bus.
  AW and W are captured independently; each accepted request becomes one
  sys_wen or sys_ren pulse, and the bus acknowledge produces the response.
  Bursts are refused with SLVERR without any bus access.
*/

`timescale 1ns/1ps

module axi4_slave (
  input  logic                          clk,
  input  logic                          rst_n_i,
  // Write address
  input  logic                          awvalid_i,
  input  logic [axi_pkg::AXI_IW-1:0]    awid_i,
  input  logic [axi_pkg::AXI_AW-1:0]    awaddr_i,
  input  logic [axi_pkg::AXI_LW-1:0]    awlen_i,
  input  logic [axi_pkg::AXI_SZW-1:0]   awsize_i,
  input  axi_pkg::axi_burst_e           awburst_i,
  output logic                          awready_o,
  // Write data
  input  logic                          wvalid_i,
  input  logic [axi_pkg::AXI_IW-1:0]    wid_i,
  input  logic [axi_pkg::AXI_DW-1:0]    wdata_i,
  input  logic [axi_pkg::AXI_SW-1:0]    wstrb_i,
  input  logic                          wlast_i,
  output logic                          wready_o,
  // Write response
  output logic                          bvalid_o,
  output logic [axi_pkg::AXI_IW-1:0]    bid_o,
  output axi_pkg::axi_resp_e            bresp_o,
  input  logic                          bready_i,
  // Read address
  input  logic                          arvalid_i,
  input  logic [axi_pkg::AXI_IW-1:0]    arid_i,
  input  logic [axi_pkg::AXI_AW-1:0]    araddr_i,
  input  logic [axi_pkg::AXI_LW-1:0]    arlen_i,
  input  logic [axi_pkg::AXI_SZW-1:0]   arsize_i,
  input  axi_pkg::axi_burst_e           arburst_i,
  output logic                          arready_o,
  // Read data
  output logic                          rvalid_o,
  output logic [axi_pkg::AXI_IW-1:0]    rid_o,
  output logic [axi_pkg::AXI_DW-1:0]    rdata_o,
  output axi_pkg::axi_resp_e            rresp_o,
  output logic                          rlast_o,
  input  logic                          rready_i,
  // System bus
  output logic [sys_pkg::SYS_AW-1:0]    sys_addr_o,
  output logic [sys_pkg::SYS_DW-1:0]    sys_wdata_o,
  output logic                          sys_wen_o,
  output logic                          sys_ren_o,
  input  logic                          sys_ack_i,
  input  logic [sys_pkg::SYS_DW-1:0]    sys_rdata_i,
  input  logic                          sys_err_i
);

typedef enum logic [2:0] {
  IDLE,
  WR_BUS,
  WR_RESP,
  RD_BUS,
  RD_RESP,
  ERR_RESP
} state_e;

state_e                       state;
logic                         aw_held;
logic                         w_held;
logic [axi_pkg::AXI_IW-1:0]   aw_id;
logic [axi_pkg::AXI_AW-1:0]   aw_addr;
logic [axi_pkg::AXI_LW-1:0]   aw_len;
logic [axi_pkg::AXI_DW-1:0]   w_data;
logic                         w_last;
logic                         aw_hs;
logic                         w_hs;
logic                         ar_hs;
logic                         wr_go;
logic                         wr_bad;

//////////////////////////////
// Handshakes

assign awready_o = (state == IDLE) && !aw_held;
assign wready_o  = (state == IDLE) && !w_held;
// Reads wait while any part of a write is pending or offered
assign arready_o = (state == IDLE) && !aw_held && !w_held && !awvalid_i && !wvalid_i;

assign aw_hs = awvalid_i && awready_o;
assign w_hs  = wvalid_i && wready_o;
assign ar_hs = arvalid_i && arready_o;

// Both write channels in hand
assign wr_go  = (state == IDLE) && aw_held && w_held;
assign wr_bad = (aw_len != '0) || !w_last;

// One beat per response
assign rlast_o = rvalid_o;

//////////////////////////////
// Control FSM

always_ff @(posedge clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    state     <= IDLE;
    aw_held   <= 1'b0;
    w_held    <= 1'b0;
    sys_wen_o <= 1'b0;
    sys_ren_o <= 1'b0;
    bvalid_o  <= 1'b0;
    rvalid_o  <= 1'b0;
    bresp_o   <= axi_pkg::OKAY;
    rresp_o   <= axi_pkg::OKAY;
  end else begin
    sys_wen_o <= 1'b0;
    sys_ren_o <= 1'b0;
    if (aw_hs) begin
      aw_held <= 1'b1;
    end
    if (w_hs) begin
      w_held <= 1'b1;
    end
    case (state)
      IDLE: begin
        if (wr_go) begin
          aw_held <= 1'b0;
          w_held  <= 1'b0;
          if (wr_bad) begin
            bresp_o  <= axi_pkg::SLVERR;
            bvalid_o <= 1'b1;
            state    <= ERR_RESP;
          end else begin
            sys_wen_o <= 1'b1;
            state     <= WR_BUS;
          end
        end else if (ar_hs) begin
          if (arlen_i != '0) begin
            rresp_o  <= axi_pkg::SLVERR;
            rvalid_o <= 1'b1;
            state    <= ERR_RESP;
          end else begin
            sys_ren_o <= 1'b1;
            state     <= RD_BUS;
          end
        end
      end
      WR_BUS: begin
        if (sys_ack_i) begin
          bresp_o  <= sys_err_i ? axi_pkg::SLVERR : axi_pkg::OKAY;
          bvalid_o <= 1'b1;
          state    <= WR_RESP;
        end
      end
      WR_RESP: begin
        if (bready_i) begin
          bvalid_o <= 1'b0;
          state    <= IDLE;
        end
      end
      RD_BUS: begin
        if (sys_ack_i) begin
          rresp_o  <= sys_err_i ? axi_pkg::SLVERR : axi_pkg::OKAY;
          rvalid_o <= 1'b1;
          state    <= RD_RESP;
        end
      end
      RD_RESP: begin
        if (rready_i) begin
          rvalid_o <= 1'b0;
          state    <= IDLE;
        end
      end
      ERR_RESP: begin
        // Either channel may carry the refusal
        if (bvalid_o && bready_i) begin
          bvalid_o <= 1'b0;
          state    <= IDLE;
        end
        if (rvalid_o && rready_i) begin
          rvalid_o <= 1'b0;
          state    <= IDLE;
        end
      end
      default: state <= IDLE;
    endcase
  end
end

//////////////////////////////
// Payload capture

always_ff @(posedge clk) begin
  if (aw_hs) begin
    aw_id   <= awid_i;
    aw_addr <= awaddr_i;
    aw_len  <= awlen_i;
  end
  if (w_hs) begin
    w_data <= wdata_i;
    w_last <= wlast_i;
  end
  if (wr_go) begin
    sys_addr_o  <= aw_addr;
    sys_wdata_o <= w_data;
    bid_o       <= aw_id;
  end else if (ar_hs) begin
    sys_addr_o <= araddr_i;
    rid_o      <= arid_i;
    rdata_o    <= '0;
  end
  if ((state == RD_BUS) && sys_ack_i) begin
    rdata_o <= sys_rdata_i;
  end
end

endmodule

// File: sys_regs.sv
/*
  Register bank on the system bus.
  Acknowledges every strobe one cycle later, flags illegal accesses
  and issues the frame start pulse to the stream generator.
*/

`timescale 1ns/1ps

module sys_regs #(
  parameter logic [31:0] BUS_ID = 32'h0000_0000
) (
  input  logic                        clk,
  input  logic                        rst_n_i,
  // System bus
  input  logic [sys_pkg::SYS_AW-1:0]  sys_addr_i,
  input  logic [sys_pkg::SYS_DW-1:0]  sys_wdata_i,
  input  logic                        sys_wen_i,
  input  logic                        sys_ren_i,
  output logic                        sys_ack_o,
  output logic [sys_pkg::SYS_DW-1:0]  sys_rdata_o,
  output logic                        sys_err_o,
  // Frame control
  output logic                        frm_start_o,
  output logic [sys_pkg::FRM_W-1:0]   frm_len_o,
  output logic [sys_pkg::FRM_W-1:0]   frm_seed_o,
  input  logic                        frm_busy_i,
  input  logic                        frm_done_i
);

logic [sys_pkg::REG_AW-1:0]     reg_off;
logic [sys_pkg::SYS_DW-1:0]     scratch;
logic [sys_pkg::STS_CNT_W-1:0]  frm_cnt;
logic [sys_pkg::SYS_DW-1:0]     rd_val;
logic                           wr_ok;
logic                           rd_ok;

// Upper address bits select the slave upstream
assign reg_off = sys_addr_i[sys_pkg::REG_AW-1:0];

//////////////////////////////
// Decode

always_comb begin
  wr_ok  = 1'b0;
  rd_ok  = 1'b0;
  rd_val = '0;
  case (reg_off)
    sys_pkg::REG_ID: begin
      rd_ok  = 1'b1;
      rd_val = BUS_ID;
    end
    sys_pkg::REG_SCRATCH: begin
      wr_ok  = 1'b1;
      rd_ok  = 1'b1;
      rd_val = scratch;
    end
    sys_pkg::REG_FRAME_LEN: begin
      wr_ok  = 1'b1;
      rd_ok  = 1'b1;
      rd_val[sys_pkg::FRM_W-1:0] = frm_len_o;
    end
    sys_pkg::REG_FRAME_SEED: begin
      wr_ok  = 1'b1;
      rd_ok  = 1'b1;
      rd_val[sys_pkg::FRM_W-1:0] = frm_seed_o;
    end
    // Write-only trigger
    sys_pkg::REG_FRAME_START: wr_ok = 1'b1;
    sys_pkg::REG_STATUS: begin
      rd_ok  = 1'b1;
      rd_val[sys_pkg::STS_BUSY_BIT] = frm_busy_i;
      rd_val[sys_pkg::STS_CNT_LSB +: sys_pkg::STS_CNT_W] = frm_cnt;
    end
    default: ;
  endcase
end

//////////////////////////////
// Registers

always_ff @(posedge clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    sys_ack_o   <= 1'b0;
    sys_err_o   <= 1'b0;
    frm_start_o <= 1'b0;
    frm_cnt     <= '0;
    scratch     <= '0;
    frm_len_o   <= '0;
    frm_seed_o  <= '0;
  end else begin
    sys_ack_o   <= sys_wen_i || sys_ren_i;
    sys_err_o   <= (sys_wen_i && !wr_ok) || (sys_ren_i && !rd_ok);
    frm_start_o <= sys_wen_i && (reg_off == sys_pkg::REG_FRAME_START);
    if (frm_done_i) begin
      frm_cnt <= frm_cnt + 1'b1;
    end
    if (sys_wen_i && wr_ok) begin
      case (reg_off)
        sys_pkg::REG_SCRATCH:    scratch    <= sys_wdata_i;
        sys_pkg::REG_FRAME_LEN:  frm_len_o  <= sys_wdata_i[sys_pkg::FRM_W-1:0];
        sys_pkg::REG_FRAME_SEED: frm_seed_o <= sys_wdata_i[sys_pkg::FRM_W-1:0];
        default: ;
      endcase
    end
  end
end

// Read data is zero on an illegal read
always_ff @(posedge clk) begin
  if (sys_ren_i) begin
    sys_rdata_o <= rd_val;
  end
end

endmodule

// File: str_frame_gen.sv
/*
  Stream frame generator.
  On a start pulse it sends len beats of seed, seed+1, ... and marks the
  last one with tlast. Beats advance only when the sink is ready.
*/

`timescale 1ns/1ps

module str_frame_gen #(
  parameter int unsigned DN = 2
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  // Frame control
  input  logic                       frm_start_i,
  input  logic [sys_pkg::FRM_W-1:0]  frm_len_i,
  input  logic [sys_pkg::FRM_W-1:0]  frm_seed_i,
  output logic                       frm_busy_o,
  output logic                       frm_done_o,
  // Stream output
  output logic [8*DN-1:0]            str_tdata_o,
  output logic [DN-1:0]              str_tkeep_o,
  output logic                       str_tlast_o,
  output logic                       str_tvalid_o,
  input  logic                       str_tready_i
);

logic [sys_pkg::FRM_W-1:0]  word;
// Beats still to come after the current one
logic [sys_pkg::FRM_W-1:0]  remain;
logic                       beat_ok;
logic                       start_ok;

assign beat_ok  = str_tvalid_o && str_tready_i;
assign start_ok = frm_start_i && !str_tvalid_o && (frm_len_i != '0);

assign frm_busy_o  = str_tvalid_o;
assign frm_done_o  = beat_ok && str_tlast_o;
assign str_tkeep_o = '1;
assign str_tdata_o = (8*DN)'(word);

always_ff @(posedge clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    str_tvalid_o <= 1'b0;
    str_tlast_o  <= 1'b0;
    remain       <= '0;
  end else if (start_ok) begin
    str_tvalid_o <= 1'b1;
    str_tlast_o  <= (frm_len_i == 1);
    remain       <= frm_len_i - 1'b1;
  end else if (beat_ok) begin
    if (str_tlast_o) begin
      str_tvalid_o <= 1'b0;
      str_tlast_o  <= 1'b0;
    end else begin
      str_tlast_o <= (remain == 1);
      remain      <= remain - 1'b1;
    end
  end
end

// Data word wraps at 16 bits
always_ff @(posedge clk) begin
  if (start_ok) begin
    word <= frm_seed_i;
  end else if (beat_ok) begin
    word <= word + 1'b1;
  end
end

endmodule

// File: ps_bridge.sv
/*
  PL side of the PS wrapper.
  The GP0 AXI slave drives the register bank over the system bus;
  the register bank starts frames on the 16-bit stream output.
*/

`timescale 1ns/1ps

module ps_bridge #(
  parameter logic [31:0] BUS_ID = 32'h5250_0001,
  parameter int unsigned DN     = 2
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  // AXI GP0
  input  logic                         awvalid_i,
  input  logic [axi_pkg::AXI_IW-1:0]   awid_i,
  input  logic [axi_pkg::AXI_AW-1:0]   awaddr_i,
  input  logic [axi_pkg::AXI_LW-1:0]   awlen_i,
  input  logic [axi_pkg::AXI_SZW-1:0]  awsize_i,
  input  axi_pkg::axi_burst_e          awburst_i,
  output logic                         awready_o,
  input  logic                         wvalid_i,
  input  logic [axi_pkg::AXI_IW-1:0]   wid_i,
  input  logic [axi_pkg::AXI_DW-1:0]   wdata_i,
  input  logic [axi_pkg::AXI_SW-1:0]   wstrb_i,
  input  logic                         wlast_i,
  output logic                         wready_o,
  output logic                         bvalid_o,
  output logic [axi_pkg::AXI_IW-1:0]   bid_o,
  output axi_pkg::axi_resp_e           bresp_o,
  input  logic                         bready_i,
  input  logic                         arvalid_i,
  input  logic [axi_pkg::AXI_IW-1:0]   arid_i,
  input  logic [axi_pkg::AXI_AW-1:0]   araddr_i,
  input  logic [axi_pkg::AXI_LW-1:0]   arlen_i,
  input  logic [axi_pkg::AXI_SZW-1:0]  arsize_i,
  input  axi_pkg::axi_burst_e          arburst_i,
  output logic                         arready_o,
  output logic                         rvalid_o,
  output logic [axi_pkg::AXI_IW-1:0]   rid_o,
  output logic [axi_pkg::AXI_DW-1:0]   rdata_o,
  output axi_pkg::axi_resp_e           rresp_o,
  output logic                         rlast_o,
  input  logic                         rready_i,
  // Stream output
  output logic [8*DN-1:0]              str_tdata_o,
  output logic [DN-1:0]                str_tkeep_o,
  output logic                         str_tlast_o,
  output logic                         str_tvalid_o,
  input  logic                         str_tready_i
);

//////////////////////////////
// System bus and frame control

logic [sys_pkg::SYS_AW-1:0]  sys_addr;
logic [sys_pkg::SYS_DW-1:0]  sys_wdata;
logic                        sys_wen;
logic                        sys_ren;
logic                        sys_ack;
logic [sys_pkg::SYS_DW-1:0]  sys_rdata;
logic                        sys_err;
logic                        frm_start;
logic [sys_pkg::FRM_W-1:0]   frm_len;
logic [sys_pkg::FRM_W-1:0]   frm_seed;
logic                        frm_busy;
logic                        frm_done;

axi4_slave axi_slave_gp0 (
  .clk, .rst_n_i,
  .awvalid_i, .awid_i, .awaddr_i, .awlen_i, .awsize_i, .awburst_i, .awready_o,
  .wvalid_i, .wid_i, .wdata_i, .wstrb_i, .wlast_i, .wready_o,
  .bvalid_o, .bid_o, .bresp_o, .bready_i,
  .arvalid_i, .arid_i, .araddr_i, .arlen_i, .arsize_i, .arburst_i, .arready_o,
  .rvalid_o, .rid_o, .rdata_o, .rresp_o, .rlast_o, .rready_i,
  .sys_addr_o  (sys_addr),
  .sys_wdata_o (sys_wdata),
  .sys_wen_o   (sys_wen),
  .sys_ren_o   (sys_ren),
  .sys_ack_i   (sys_ack),
  .sys_rdata_i (sys_rdata),
  .sys_err_i   (sys_err)
);

sys_regs #(.BUS_ID (BUS_ID)) regs (
  .clk, .rst_n_i,
  .sys_addr_i  (sys_addr),
  .sys_wdata_i (sys_wdata),
  .sys_wen_i   (sys_wen),
  .sys_ren_i   (sys_ren),
  .sys_ack_o   (sys_ack),
  .sys_rdata_o (sys_rdata),
  .sys_err_o   (sys_err),
  .frm_start_o (frm_start),
  .frm_len_o   (frm_len),
  .frm_seed_o  (frm_seed),
  .frm_busy_i  (frm_busy),
  .frm_done_i  (frm_done)
);

str_frame_gen #(.DN (DN)) frame_gen (
  .clk, .rst_n_i,
  .frm_start_i (frm_start),
  .frm_len_i   (frm_len),
  .frm_seed_i  (frm_seed),
  .frm_busy_o  (frm_busy),
  .frm_done_o  (frm_done),
  .str_tdata_o, .str_tkeep_o, .str_tlast_o, .str_tvalid_o, .str_tready_i
);

endmodule

// File: tb_ps_bridge_asserts.sv
/*
  Protocol assertions bound into the PS bridge top level.
  Covers response hold on B and R and stream stability under back-pressure.
*/

`timescale 1ns/1ps

module tb_ps_bridge_asserts #(
  parameter int unsigned DN = 2
) (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             bvalid_i,
  input  logic             bready_i,
  input  logic             rvalid_i,
  input  logic             rready_i,
  input  logic [8*DN-1:0]  str_tdata_i,
  input  logic             str_tlast_i,
  input  logic             str_tvalid_i,
  input  logic             str_tready_i
);

//////////////////////////////
// AXI responses

b_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
  bvalid_i && !bready_i |=> bvalid_i)
  else $error("bvalid dropped before bready");

r_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
  rvalid_i && !rready_i |=> rvalid_i)
  else $error("rvalid dropped before rready");

//////////////////////////////
// Stream

// Stalled beat keeps its data
t_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
  str_tvalid_i && !str_tready_i |=> str_tvalid_i && $stable(str_tdata_i))
  else $error("tdata changed while stalled");

t_last: assert property (@(posedge clk) disable iff (!rst_n_i)
  str_tlast_i |-> str_tvalid_i)
  else $error("tlast high without tvalid");

endmodule

bind ps_bridge tb_ps_bridge_asserts #(.DN (DN)) ps_bridge_asserts_i (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .bvalid_i     (bvalid_o),
  .bready_i     (bready_i),
  .rvalid_i     (rvalid_o),
  .rready_i     (rready_i),
  .str_tdata_i  (str_tdata_o),
  .str_tlast_i  (str_tlast_o),
  .str_tvalid_i (str_tvalid_o),
  .str_tready_i (str_tready_i)
);

// File: tb_ps_bridge.sv
/*
  Testbench for the PS bridge. Reads the operation list from the testdata
  file, drives AXI reads and writes, sinks the stream under random tready
  and checks responses, IDs, read data and frame contents.
*/

`timescale 1ns/1ps

module tb_ps_bridge;

localparam int unsigned DN   = 2;
localparam logic [31:0] SEED = 32'hb37015e9;

logic                          clk;
logic                          rst_n_i;
logic                          awvalid_i;
logic [axi_pkg::AXI_IW-1:0]    awid_i;
logic [axi_pkg::AXI_AW-1:0]    awaddr_i;
logic [axi_pkg::AXI_LW-1:0]    awlen_i;
logic [axi_pkg::AXI_SZW-1:0]   awsize_i;
axi_pkg::axi_burst_e           awburst_i;
logic                          awready_o;
logic                          wvalid_i;
logic [axi_pkg::AXI_IW-1:0]    wid_i;
logic [axi_pkg::AXI_DW-1:0]    wdata_i;
logic [axi_pkg::AXI_SW-1:0]    wstrb_i;
logic                          wlast_i;
logic                          wready_o;
logic                          bvalid_o;
logic [axi_pkg::AXI_IW-1:0]    bid_o;
axi_pkg::axi_resp_e            bresp_o;
logic                          bready_i;
logic                          arvalid_i;
logic [axi_pkg::AXI_IW-1:0]    arid_i;
logic [axi_pkg::AXI_AW-1:0]    araddr_i;
logic [axi_pkg::AXI_LW-1:0]    arlen_i;
logic [axi_pkg::AXI_SZW-1:0]   arsize_i;
axi_pkg::axi_burst_e           arburst_i;
logic                          arready_o;
logic                          rvalid_o;
logic [axi_pkg::AXI_IW-1:0]    rid_o;
logic [axi_pkg::AXI_DW-1:0]    rdata_o;
axi_pkg::axi_resp_e            rresp_o;
logic                          rlast_o;
logic                          rready_i;
logic [8*DN-1:0]               str_tdata_o;
logic [DN-1:0]                 str_tkeep_o;
logic                          str_tlast_o;
logic                          str_tvalid_o;
logic                          str_tready_i;

// Parsed operation list
byte                           op_q[$];
logic [31:0]                   f1_q[$];
logic [31:0]                   f2_q[$];
logic [31:0]                   f3_q[$];
logic [31:0]                   f4_q[$];
// Accepted stream beats
logic [8*DN-1:0]               bdata_q[$];
logic                          blast_q[$];
logic [DN-1:0]                 bkeep_q[$];

logic [sys_pkg::FRM_W-1:0]     exp_len;
logic [sys_pkg::FRM_W-1:0]     exp_seed;
logic [axi_pkg::AXI_IW-1:0]    next_id;
int                            cyc;
int                            limit;

ps_bridge #(.BUS_ID (32'h5250_0001), .DN (DN)) ps_bridge_i (.*);

always #20 clk = ~clk;

//////////////////////////////
// Reporting and compares

task automatic report_fail(input string msg);
  $display("%s", msg);
  $display("FAIL: see errors above");
  $fatal(1, "simulation stopped on error");
endtask

task automatic check_resp(input string name, input axi_pkg::axi_resp_e exp,
                          input axi_pkg::axi_resp_e act);
  if (act !== exp)
    report_fail($sformatf("FAIL t=%0t %s expected %s actual %s",
                          $time, name, exp.name(), act.name()));
endtask

task automatic check_data(input string name, input logic [sys_pkg::SYS_DW-1:0] exp,
                          input logic [sys_pkg::SYS_DW-1:0] act);
  if (act !== exp)
    report_fail($sformatf("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act));
endtask

task automatic check_id(input string name, input logic [axi_pkg::AXI_IW-1:0] exp,
                        input logic [axi_pkg::AXI_IW-1:0] act);
  if (act !== exp)
    report_fail($sformatf("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp)
    report_fail($sformatf("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act));
endtask

task automatic check_beat(input logic [8*DN-1:0] exp_data, input logic exp_last,
                          input logic [8*DN-1:0] act_data, input logic act_last,
                          input logic [DN-1:0] act_keep);
  if (act_data !== exp_data)
    report_fail($sformatf("FAIL t=%0t str_tdata_o expected %h actual %h",
                          $time, exp_data, act_data));
  check_flag("str_tlast_o", exp_last, act_last);
  if (act_keep !== '1)
    report_fail($sformatf("FAIL t=%0t str_tkeep_o expected %h actual %h",
                          $time, {DN{1'b1}}, act_keep));
endtask

//////////////////////////////
// Operation list

task automatic read_file();
  int          fd;
  int          n;
  string       line;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] c;
  logic [31:0] d;
  fd = $fopen("ps_bridge_testdata.txt", "r");
  if (fd == 0)
    report_fail("cannot open ps_bridge_testdata.txt");
  while ($fgets(line, fd) != 0) begin
    if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
      continue;
    a = '0;
    b = '0;
    c = '0;
    d = '0;
    if (line.getc(0) == "W" || line.getc(0) == "R") begin
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
      if (n != 4)
        report_fail($sformatf("malformed testdata line: %s", line));
    end else if (line.getc(0) != "F") begin
      report_fail($sformatf("unknown operation in testdata: %s", line));
    end
    op_q.push_back(line.getc(0));
    f1_q.push_back(a);
    f2_q.push_back(b);
    f3_q.push_back(c);
    f4_q.push_back(d);
  end
  $fclose(fd);
endtask

// Count of frame words in the file for the timeout budget
function automatic int frame_words();
  int                        words;
  logic [sys_pkg::FRM_W-1:0] len;
  words = 0;
  len   = '0;
  foreach (op_q[i]) begin
    if (op_q[i] == "W" && f4_q[i] == 0 && f1_q[i][7:0] == 8'(sys_pkg::REG_FRAME_LEN))
      len = f2_q[i][sys_pkg::FRM_W-1:0];
    if (op_q[i] == "F")
      words += int'(len);
  end
  return words;
endfunction

//////////////////////////////
// AXI master and stream sink

task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [axi_pkg::AXI_LW-1:0] len,
                         input axi_pkg::axi_resp_e exp_resp);
  logic aw_done;
  logic w_done;
  aw_done = 1'b0;
  w_done  = 1'b0;
  @(posedge clk);
  awvalid_i <= 1'b1;
  awid_i    <= next_id;
  awaddr_i  <= addr;
  awlen_i   <= len;
  wvalid_i  <= 1'b1;
  wid_i     <= next_id;
  wdata_i   <= data;
  while (!(aw_done && w_done)) begin
    @(posedge clk);
    if (awvalid_i && awready_o) begin
      awvalid_i <= 1'b0;
      aw_done = 1'b1;
    end
    if (wvalid_i && wready_o) begin
      wvalid_i <= 1'b0;
      w_done = 1'b1;
    end
  end
  do @(posedge clk); while (!bvalid_o);
  check_resp("bresp_o", exp_resp, bresp_o);
  check_id("bid_o", next_id, bid_o);
  // Stall B for one cycle before accepting it
  bready_i <= 1'b1;
  @(posedge clk);
  bready_i <= 1'b0;
  // Track what the generator will use on the next start
  if (exp_resp == axi_pkg::OKAY && addr[7:0] == 8'(sys_pkg::REG_FRAME_LEN))
    exp_len = data[sys_pkg::FRM_W-1:0];
  if (exp_resp == axi_pkg::OKAY && addr[7:0] == 8'(sys_pkg::REG_FRAME_SEED))
    exp_seed = data[sys_pkg::FRM_W-1:0];
  next_id = next_id + 12'h135;
endtask

task automatic axi_read(input logic [31:0] addr, input logic [axi_pkg::AXI_LW-1:0] len,
                        input logic [31:0] exp_data, input axi_pkg::axi_resp_e exp_resp);
  @(posedge clk);
  arvalid_i <= 1'b1;
  arid_i    <= next_id;
  araddr_i  <= addr;
  arlen_i   <= len;
  do @(posedge clk); while (!(arvalid_i && arready_o));
  arvalid_i <= 1'b0;
  do @(posedge clk); while (!rvalid_o);
  check_resp("rresp_o", exp_resp, rresp_o);
  check_id("rid_o", next_id, rid_o);
  check_flag("rlast_o", 1'b1, rlast_o);
  if (exp_resp == axi_pkg::OKAY)
    check_data("rdata_o", exp_data, rdata_o);
  // Stall R for one cycle before accepting it
  rready_i <= 1'b1;
  @(posedge clk);
  rready_i <= 1'b0;
  next_id = next_id + 12'h135;
endtask

task automatic run_frame();
  logic [sys_pkg::FRM_W-1:0] word;
  word = exp_seed;
  for (int k = 0; k < int'(exp_len); k++) begin
    while (bdata_q.size() == 0)
      @(posedge clk);
    check_beat(word, k == int'(exp_len) - 1, bdata_q.pop_front(), blast_q.pop_front(),
               bkeep_q.pop_front());
    word = word + 1'b1;
  end
endtask

always @(posedge clk) begin
  if (rst_n_i && str_tvalid_o && str_tready_i) begin
    bdata_q.push_back(str_tdata_o);
    blast_q.push_back(str_tlast_o);
    bkeep_q.push_back(str_tkeep_o);
  end
end

// Sink ready about 70% of cycles
always @(posedge clk) begin
  if (rst_n_i)
    str_tready_i <= (($urandom % 100) < 70);
end

always @(posedge clk) begin
  cyc = cyc + 1;
  if (limit != 0 && cyc > limit)
    report_fail($sformatf("timeout: run exceeded %0d cycles", limit));
end

//////////////////////////////
// Main sequence

initial begin
  clk          = 1'b0;
  rst_n_i      = 1'b0;
  awvalid_i    = 1'b0;
  awid_i       = '0;
  awaddr_i     = '0;
  awlen_i      = '0;
  awsize_i     = 3'd2;
  awburst_i    = axi_pkg::INCR;
  wvalid_i     = 1'b0;
  wid_i        = '0;
  wdata_i      = '0;
  wstrb_i      = '1;
  wlast_i      = 1'b1;
  bready_i     = 1'b0;
  arvalid_i    = 1'b0;
  arid_i       = '0;
  araddr_i     = '0;
  arlen_i      = '0;
  arsize_i     = 3'd2;
  arburst_i    = axi_pkg::INCR;
  rready_i     = 1'b0;
  str_tready_i = 1'b0;
  exp_len      = '0;
  exp_seed     = '0;
  next_id      = 12'h3a1;
  cyc          = 0;
  limit        = 0;
  void'($urandom(SEED));
  read_file();
  limit = 50 * op_q.size() + 4 * frame_words() + 20;
  repeat (3) @(posedge clk);
  rst_n_i <= 1'b1;
  foreach (op_q[i]) begin
    case (op_q[i])
      "W": axi_write(f1_q[i], f2_q[i], f3_q[i][axi_pkg::AXI_LW-1:0],
                     axi_pkg::axi_resp_e'(f4_q[i][1:0]));
      "R": axi_read(f1_q[i], f2_q[i][axi_pkg::AXI_LW-1:0], f3_q[i],
                    axi_pkg::axi_resp_e'(f4_q[i][1:0]));
      default: run_frame();
    endcase
  end
  repeat (4) @(posedge clk);
  if (bdata_q.size() == 0) begin
    $display("PASS: all tests");
    $finish;
  end else begin
    report_fail($sformatf("stream delivered %0d beats beyond the expected frames",
                          bdata_q.size()));
  end
end

endmodule

// File: ps_bridge_testdata.txt
# W <addr> <wdata> <awlen> <bresp>    write and expected response, hex
# R <addr> <arlen> <rdata> <rresp>    read, data compared on OKAY only; F waits for one frame
R 00 0 52500001 0
W 04 a5a5f00d 0 0
R 04 0 a5a5f00d 0
W 00 12345678 0 2
R 00 0 52500001 0
W 40 deadbeef 0 2
R 40 0 00000000 2
R 10 0 00000000 2
W 14 00000001 0 2
W 04 11112222 3 2
R 04 1 00000000 2
R 04 0 a5a5f00d 0
W 08 00000005 0 0
W 0c 0000fffe 0 0
W 10 00000001 0 0
F
R 14 0 00010000 0
W 08 00000000 0 0
W 10 00000001 0 0
R 14 0 00010000 0
W 08 00000011 0 0
W 0c 00007ff8 0 0
W 10 00000001 0 0
F
R 14 0 00020000 0
R 0c 0 00007ff8 0

// File: filelist.f
axi_pkg.sv
sys_pkg.sv
axi4_slave.sv
sys_regs.sv
str_frame_gen.sv
ps_bridge.sv
tb_ps_bridge_asserts.sv
tb_ps_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 --top-module tb_ps_bridge \
  -f filelist.f -o sim_ps_bridge > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_ps_bridge > sim.log 2>&1

grep -q "^PASS: all tests$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
